// File: project.f
+incdir+design
design/core_pkg.sv
design/pipe_if.sv
design/fetch_stage.sv
design/hazard_detection_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/core_top.sv
bench/core_properties.sv
bench/core_checker.sv
bench/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module core_tb --Mdir "$BUILD_DIR" -o core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/core_sim" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q -F '** FAIL **' "$LOG_FILE"; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q -F '** PASS **' "$LOG_FILE"; then
  echo "Simulation ended without a result line"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: bench/core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core testbench
// Clock, reset, instruction responder, program and reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module core_tb;

  localparam int          PROG_LEN       = 40;
  localparam int          CLK_HALF       = 2;
  localparam int          RESET_CYCLES   = 10;
  localparam int          ACK_DELAY_MAX  = 5;
  // Ack delay plus request, capture, drop and re-request
  localparam int          FETCH_WORST    = ACK_DELAY_MAX + 4;
  localparam int          MUL_LEN        = `CORE_MUL_CYCLES + 1;
  localparam int          TIMEOUT_CYCLES = RESET_CYCLES + PROG_LEN * (FETCH_WORST + MUL_LEN);
  localparam int          DRAIN_CYCLES   = 10;
  localparam logic [31:0] RAND_SEED      = 32'h8784;

  // Test groups
  localparam int T_ADD  = 0;
  localparam int T_LOAD = 1;
  localparam int T_MUL  = 2;
  localparam int T_X0   = 3;

  logic                    clk;
  logic                    arst_n;
  logic                    imem_req;
  logic [`CORE_XLEN-1:0]   imem_addr;
  logic                    imem_ack;
  logic [`CORE_XLEN-1:0]   imem_data;
  logic                    retire_valid;
  logic [`CORE_REG_AW-1:0] retire_rd;
  logic [`CORE_XLEN-1:0]   retire_data;

  logic [`CORE_XLEN-1:0]   prog      [PROG_LEN];
  int                      prog_test [PROG_LEN];
  logic [`CORE_REG_AW-1:0] exp_rd    [PROG_LEN];
  logic [`CORE_XLEN-1:0]   exp_data  [PROG_LEN];
  logic [`CORE_XLEN-1:0]   ref_regs  [`CORE_REG_NUM];
  int                      fill_idx;
  int                      value_errors;
  int                      retired;
  int                      assert_errors;

  core_top DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .imem_ack     (imem_ack),
    .imem_data    (imem_data),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  core_checker #(.N(PROG_LEN)) u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .exp_rd       (exp_rd),
    .exp_data     (exp_data),
    .exp_test     (prog_test),
    .error_count  (value_errors),
    .retire_count (retired)
  );

  // Handshake checks sit on fetch, hazard checks on decode
  bind fetch_stage core_properties u_hs_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .imem_req    (imem_req),
    .imem_ack    (imem_ack),
    .imem_addr   (imem_addr),
    .stall_pc    (1'b0),
    .bubble_idex (1'b0)
  );

  bind decode_stage core_properties u_hz_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .imem_req    (1'b0),
    .imem_ack    (1'b0),
    .imem_addr   ({`CORE_XLEN{1'b0}}),
    .stall_pc    (stall_pc),
    .bubble_idex (bubble_idex)
  );

  assign assert_errors = DUT.u_fetch.u_hs_props.fail_count +
                         DUT.u_decode.u_hz_props.fail_count;

  // Register-register word, funct3 zero
  function automatic logic [31:0] r_format(input logic [6:0] f7, input int rd,
                                           input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], `CORE_OPC_OP};
  endfunction

  function automatic logic [31:0] i_format(input logic [6:0] opc, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  task automatic put_instr(input logic [31:0] word, input int test);
    prog[fill_idx]      = word;
    prog_test[fill_idx] = test;
    fill_idx            = fill_idx + 1;
  endtask

  task automatic load_program();
    fill_idx = 0;
    // Independent and chained adds
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 1, 0, 5), T_ADD);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 2, 0, -3), T_ADD);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 3, 0, 100), T_ADD);
    put_instr(r_format(7'd0, 4, 1, 2), T_ADD);
    put_instr(r_format(7'd0, 5, 3, 1), T_ADD);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 6, 4, 7), T_ADD);
    put_instr(r_format(7'd0, 7, 5, 6), T_ADD);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 8, 0, 2047), T_ADD);
    put_instr(r_format(7'd0, 9, 8, 8), T_ADD);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 10, 9, -2048), T_ADD);
    put_instr(r_format(7'd0, 10, 10, 10), T_ADD);
    // Loads with the next word using the result
    put_instr(i_format(`CORE_OPC_LOAD, 3'b010, 11, 0, 0), T_LOAD);
    put_instr(r_format(7'd0, 12, 11, 1), T_LOAD);
    put_instr(i_format(`CORE_OPC_LOAD, 3'b010, 13, 0, 8), T_LOAD);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 14, 13, 1), T_LOAD);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 15, 0, 20), T_LOAD);
    put_instr(i_format(`CORE_OPC_LOAD, 3'b010, 16, 15, 4), T_LOAD);
    put_instr(r_format(7'd0, 17, 16, 16), T_LOAD);
    put_instr(i_format(`CORE_OPC_LOAD, 3'b010, 18, 0, 60), T_LOAD);
    put_instr(r_format(7'd0, 19, 18, 11), T_LOAD);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 13, 0, 44), T_LOAD);
    put_instr(i_format(`CORE_OPC_LOAD, 3'b010, 13, 13, 0), T_LOAD);
    put_instr(r_format(7'd0, 14, 13, 13), T_LOAD);
    // Multiplies and their consumers
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 20, 0, 7), T_MUL);
    put_instr(r_format(`CORE_F7_MUL, 21, 20, 20), T_MUL);
    put_instr(r_format(7'd0, 22, 21, 20), T_MUL);
    put_instr(r_format(`CORE_F7_MUL, 23, 2, 3), T_MUL);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 24, 23, 1), T_MUL);
    put_instr(r_format(`CORE_F7_MUL, 25, 21, 23), T_MUL);
    put_instr(r_format(`CORE_F7_MUL, 26, 25, 25), T_MUL);
    put_instr(r_format(7'd0, 27, 26, 1), T_MUL);
    put_instr(i_format(`CORE_OPC_LOAD, 3'b010, 28, 0, 12), T_MUL);
    put_instr(r_format(`CORE_F7_MUL, 29, 28, 20), T_MUL);
    // Writes to x0 followed by reads of x0
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 0, 0, 55), T_X0);
    put_instr(r_format(7'd0, 0, 1, 3), T_X0);
    put_instr(r_format(7'd0, 30, 0, 0), T_X0);
    put_instr(r_format(`CORE_F7_MUL, 0, 20, 20), T_X0);
    put_instr(i_format(`CORE_OPC_OPIMM, 3'b000, 30, 0, 1), T_X0);
    put_instr(i_format(`CORE_OPC_LOAD, 3'b010, 0, 0, 4), T_X0);
    put_instr(r_format(7'd0, 31, 0, 1), T_X0);
  endtask

  // Architectural model of one instruction
  function automatic void ref_execute(input logic [31:0] word,
                                      output logic [`CORE_REG_AW-1:0] rd,
                                      output logic [`CORE_XLEN-1:0] value);
    logic [6:0]  opcode;
    logic [6:0]  funct7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    opcode = word[6:0];
    funct7 = word[31:25];
    rd     = word[11:7];
    a      = ref_regs[word[19:15]];
    b      = ref_regs[word[24:20]];
    imm    = {{20{word[31]}}, word[31:20]};
    case (opcode)
      `CORE_OPC_OP:    value = (funct7 == `CORE_F7_MUL) ? a * b : a + b;
      `CORE_OPC_OPIMM: value = a + imm;
      `CORE_OPC_LOAD: begin
        addr  = a + imm;
        // Memory word holds seed xor its word address
        value = `CORE_DMEM_SEED ^ (addr >> 2);
      end
      default:         value = '0;
    endcase
    if (rd != '0) begin
      ref_regs[rd] = value;
    end
  endfunction

  task automatic build_expected();
    for (int r = 0; r < `CORE_REG_NUM; r++) begin
      ref_regs[r] = '0;
    end
    for (int k = 0; k < PROG_LEN; k++) begin
      ref_execute(prog[k], exp_rd[k], exp_data[k]);
    end
  endtask

  task automatic report_and_finish(input bit hung);
    int total;
    total = value_errors + assert_errors + (hung ? 1 : 0);
    $display("Errors: %0d value, %0d assertion, %0d hang; retired %0d of %0d",
             value_errors, assert_errors, hung ? 1 : 0, retired, PROG_LEN);
    if (total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // Four-phase source, words past the program end are never acked
  initial begin : responder
    int unsigned delay;
    int          word_idx;
    // Ack delays are drawn in this process
    void'($urandom(RAND_SEED));
    imem_ack  = 1'b0;
    imem_data = '0;
    forever begin
      @(posedge clk);
      word_idx = int'(imem_addr >> 2);
      if (arst_n && imem_req && !imem_ack && (word_idx < PROG_LEN)) begin
        delay = $urandom % (ACK_DELAY_MAX + 1);
        repeat (delay) @(posedge clk);
        imem_ack  <= 1'b1;
        imem_data <= prog[word_idx];
        @(posedge clk);
        // Hold ack until fetch drops its request
        while (imem_req) @(posedge clk);
        imem_ack <= 1'b0;
      end
    end
  end

  initial begin : main_seq
    arst_n = 1'b0;
    load_program();
    build_expected();
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    wait (retired == PROG_LEN);
    // Catch any extra retire still in the pipe
    repeat (DRAIN_CYCLES) @(posedge clk);
    report_and_finish(1'b0);
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Watchdog expired: pipeline hung with %0d of %0d instructions retired",
             retired, PROG_LEN);
    report_and_finish(1'b1);
  end

endmodule

`default_nettype wire

// File: bench/core_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core checker
// Compares each retired instruction with the expected one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module core_checker #(
  parameter int N = 40
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    retire_valid,
  input  logic [`CORE_REG_AW-1:0] retire_rd,
  input  logic [`CORE_XLEN-1:0]   retire_data,
  input  logic [`CORE_REG_AW-1:0] exp_rd   [N],
  input  logic [`CORE_XLEN-1:0]   exp_data [N],
  input  int                      exp_test [N],
  output int                      error_count,
  output int                      retire_count
);

  // Group ids as used in the program table
  function automatic string test_name(input int id);
    case (id)
      0:       return "add_seq";
      1:       return "load_use";
      2:       return "mul_dep";
      3:       return "x0_writes";
      default: return "unknown";
    endcase
  endfunction

  // Retire port is registered, so the edge sees settled values
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      error_count  <= 0;
      retire_count <= 0;
    end else if (retire_valid) begin
      if (retire_count >= N) begin
        // Duplicate or invented instruction
        $display("Unexpected retire after the last program word: rd %0d data 0x%08h",
                 retire_rd, retire_data);
        error_count <= error_count + 1;
      end else if ((retire_rd !== exp_rd[retire_count]) ||
                   (retire_data !== exp_data[retire_count])) begin
        $display("** Error: test %s, word %0d: expected rd %0d data 0x%08h, actual rd %0d data 0x%08h",
                 test_name(exp_test[retire_count]), retire_count,
                 exp_rd[retire_count], exp_data[retire_count], retire_rd, retire_data);
        error_count <= error_count + 1;
      end
      // In-order retire, one slot per program word
      retire_count <= retire_count + 1;
    end
  end

endmodule

`default_nettype wire

// File: bench/core_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core properties
// Fetch handshake and hazard control assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module core_properties (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  imem_req,
  input logic                  imem_ack,
  input logic [`CORE_XLEN-1:0] imem_addr,
  input logic                  stall_pc,
  input logic                  bubble_idex
);

  // Count of failed assertions
  int fail_count = 0;

  // Request stays up until the source acks
  req_until_ack: assert property (
    @(posedge clk) disable iff (!arst_n)
    (imem_req && !imem_ack) |=> imem_req
  ) else begin
    $error("imem_req dropped before imem_ack rose");
    fail_count = fail_count + 1;
  end

  // Address frozen for the whole request
  addr_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    (imem_req && !imem_ack) |=> $stable(imem_addr)
  ) else begin
    $error("imem_addr changed while imem_req was high");
    fail_count = fail_count + 1;
  end

  // A bubble comes with a front-end stall and lasts a single cycle
  bubble_stalls: assert property (
    @(posedge clk) disable iff (!arst_n)
    bubble_idex |=> ($past(stall_pc) && !bubble_idex)
  ) else begin
    $error("bubble_idex raised without stall_pc or held for more than one cycle");
    fail_count = fail_count + 1;
  end

endmodule

`default_nettype wire

// File: design/core_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core top level
// Four-stage integer pipeline with plain outside ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module core_top (
  input  logic                    clk,
  input  logic                    arst_n,
  // Instruction source, four-phase req/ack
  output logic                    imem_req,
  output logic [`CORE_XLEN-1:0]   imem_addr,
  input  logic                    imem_ack,
  input  logic [`CORE_XLEN-1:0]   imem_data,
  // Retire port
  output logic                    retire_valid,
  output logic [`CORE_REG_AW-1:0] retire_rd,
  output logic [`CORE_XLEN-1:0]   retire_data
);

  logic                    wb_valid;
  logic [`CORE_REG_AW-1:0] wb_rd;
  logic [`CORE_XLEN-1:0]   wb_data;
  logic                    mul_busy;
  logic                    mul_done;

  fetch_if fi ();
  id_ex_if di ();
  ex_wb_if ei ();

  fetch_stage u_fetch (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_ack  (imem_ack),
    .imem_data (imem_data),
    .fq        (fi.producer)
  );

  // Multiplier state returns to the hazard unit inside decode
  decode_stage u_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .fq       (fi.consumer),
    .dq       (di.producer),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .mul_busy (mul_busy),
    .mul_done (mul_done)
  );

  execute_stage u_execute (
    .clk      (clk),
    .arst_n   (arst_n),
    .dq       (di.consumer),
    .eq       (ei.producer),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .mul_busy (mul_busy),
    .mul_done (mul_done)
  );

  mem_wb_stage u_mem_wb (
    .clk          (clk),
    .arst_n       (arst_n),
    .eq           (ei.consumer),
    .wb_valid     (wb_valid),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

`default_nettype wire

// File: design/mem_wb_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory and write-back stage
// Data memory read, write-back select and retire outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module mem_wb_stage import core_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  ex_wb_if.consumer               eq,
  output logic                    wb_valid,
  output logic [`CORE_REG_AW-1:0] wb_rd,
  output logic [`CORE_XLEN-1:0]   wb_data,
  output logic                    retire_valid,
  output logic [`CORE_REG_AW-1:0] retire_rd,
  output logic [`CORE_XLEN-1:0]   retire_data
);

  logic [`CORE_XLEN-1:0]    dmem [`CORE_DMEM_WORDS];
  logic [`CORE_DMEM_AW-1:0] word_addr;
  logic [`CORE_XLEN-1:0]    load_data;

  // Contents follow the seed rule, no stores in this core
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int k = 0; k < `CORE_DMEM_WORDS; k++) begin
        dmem[k] <= `CORE_DMEM_SEED ^ `CORE_XLEN'(k);
      end
    end
  end

  // Byte address from execute, word index above bit 1
  assign word_addr = eq.result[`CORE_DMEM_AW+1:2];
  assign load_data = dmem[word_addr];

  // Write-back to decode and execute in the same cycle
  assign wb_valid = eq.valid;
  assign wb_rd    = eq.rd;
  assign wb_data  = (eq.op == OP_LOAD) ? load_data : eq.result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= wb_valid;
    end
  end

  // rd 0 still retires, only the register write is dropped
  always_ff @(posedge clk) begin
    retire_rd   <= wb_rd;
    retire_data <= wb_data;
  end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage
// Forwarding, adder, shift-add multiplier and EX/MEM register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module execute_stage import core_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  id_ex_if.consumer               dq,
  ex_wb_if.producer               eq,
  input  logic                    wb_valid,
  input  logic [`CORE_REG_AW-1:0] wb_rd,
  input  logic [`CORE_XLEN-1:0]   wb_data,
  output logic                    mul_busy,
  output logic                    mul_done
);

  localparam int CNT_W = $clog2(`CORE_MUL_CYCLES);

  logic [`CORE_XLEN-1:0] opa_f;
  logic [`CORE_XLEN-1:0] opb_f;
  logic [`CORE_XLEN-1:0] sum;
  logic [`CORE_XLEN-1:0] mcand;
  logic [`CORE_XLEN-1:0] mplier;
  logic [`CORE_XLEN-1:0] acc;
  logic [`CORE_XLEN-1:0] acc_next;
  logic [CNT_W-1:0]      cnt;
  logic                  is_mul;
  logic                  mul_start;

  // Write-back result overrides a stale operand
  assign opa_f = (wb_valid && (dq.rs1 != '0) && (wb_rd == dq.rs1)) ? wb_data : dq.opa;
  assign opb_f = (wb_valid && (dq.rs2 != '0) && (wb_rd == dq.rs2)) ? wb_data : dq.opb;
  // Sum for ADD, ADDI and the load address
  assign sum   = opa_f + opb_f;

  assign is_mul    = dq.valid && (dq.op == OP_MUL);
  // First EX cycle latches the forwarded operands
  assign mul_start = is_mul && !mul_busy;
  // Last step runs combinationally in the done cycle
  assign mul_done  = mul_busy && (cnt == CNT_W'(`CORE_MUL_CYCLES - 1));
  assign acc_next  = acc + (mplier[0] ? mcand : '0);

  // MUL sits in EX for CORE_MUL_CYCLES plus one cycles
  assign dq.hold = is_mul && !mul_done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mul_busy <= 1'b0;
      cnt      <= '0;
    end else if (mul_start) begin
      mul_busy <= 1'b1;
      cnt      <= '0;
    end else if (mul_busy) begin
      if (mul_done) begin
        mul_busy <= 1'b0;
      end
      cnt <= cnt + 1'b1;
    end
  end

  // One multiplier bit per cycle, low word kept
  always_ff @(posedge clk) begin
    if (mul_start) begin
      acc    <= '0;
      mcand  <= opa_f;
      mplier <= opb_f;
    end else if (mul_busy) begin
      acc    <= acc_next;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // EX/MEM register, empty while the MUL iterates
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      eq.valid <= 1'b0;
    end else begin
      eq.valid <= dq.valid && !dq.hold;
    end
  end

  always_ff @(posedge clk) begin
    eq.op     <= dq.op;
    eq.rd     <= dq.rd;
    eq.result <= (dq.op == OP_MUL) ? acc_next : sum;
  end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage
// IF/ID register, decode, register file and ID/EX register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module decode_stage import core_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  fetch_if.consumer               fq,
  id_ex_if.producer               dq,
  input  logic                    wb_valid,
  input  logic [`CORE_REG_AW-1:0] wb_rd,
  input  logic [`CORE_XLEN-1:0]   wb_data,
  input  logic                    mul_busy,
  input  logic                    mul_done
);

  logic                    ifid_valid;
  instr_word_u             ifid_instr;
  logic [`CORE_XLEN-1:0]   regs [`CORE_REG_NUM];
  logic                    stall_pc;
  logic                    stall_ifid;
  logic                    bubble_idex;
  alu_op_e                 op_dec;
  logic                    uses_rs2;
  logic [`CORE_REG_AW-1:0] rs1_id;
  logic [`CORE_REG_AW-1:0] rs2_id;
  logic [`CORE_XLEN-1:0]   imm_ext;
  logic [`CORE_XLEN-1:0]   rs1_val;
  logic [`CORE_XLEN-1:0]   rs2_val;

  // x0 reads zero, a write in this cycle passes straight through
  function automatic logic [`CORE_XLEN-1:0] rf_read(input logic [`CORE_REG_AW-1:0] idx);
    if (idx == '0) begin
      return '0;
    end
    if (wb_valid && (wb_rd == idx)) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  assign fq.stall = stall_pc;

  // IF/ID register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ifid_valid <= 1'b0;
    end else if (!stall_ifid) begin
      ifid_valid <= fq.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_ifid) begin
      ifid_instr <= fq.instr;
    end
  end

  // Register fields through the r view, immediate through the i view
  always_comb begin
    op_dec   = OP_ADD;
    uses_rs2 = 1'b0;
    case (ifid_instr.r.opcode)
      `CORE_OPC_OP: begin
        uses_rs2 = 1'b1;
        op_dec   = (ifid_instr.r.funct7 == `CORE_F7_MUL) ? OP_MUL : OP_ADD;
      end
      `CORE_OPC_OPIMM: op_dec = OP_ADD;
      `CORE_OPC_LOAD:  op_dec = OP_LOAD;
      default:         op_dec = OP_ADD;
    endcase
  end

  // Unused sources read as x0 so they raise no hazard
  assign rs1_id  = ifid_valid ? ifid_instr.r.rs1 : '0;
  assign rs2_id  = (ifid_valid && uses_rs2) ? ifid_instr.r.rs2 : '0;
  assign imm_ext = {{(`CORE_XLEN-12){ifid_instr.i.imm[11]}}, ifid_instr.i.imm};

  always_comb begin
    rs1_val = rf_read(rs1_id);
    rs2_val = rf_read(rs2_id);
  end

  // Registers start at zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int k = 0; k < `CORE_REG_NUM; k++) begin
        regs[k] <= '0;
      end
    end else if (wb_valid && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  hazard_detection_unit u_hdu (
    .idex_mem_read (dq.valid && (dq.op == OP_LOAD)),
    .idex_rd       (dq.rd),
    .ifid_rs1      (rs1_id),
    .ifid_rs2      (rs2_id),
    .mul_busy      (mul_busy),
    .idex_is_mul   (dq.valid && (dq.op == OP_MUL)),
    .mul_done      (mul_done),
    .stall_pc      (stall_pc),
    .stall_ifid    (stall_ifid),
    .bubble_idex   (bubble_idex)
  );

  // ID/EX register, frozen while execute holds
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dq.valid <= 1'b0;
    end else if (!dq.hold) begin
      dq.valid <= ifid_valid && !bubble_idex;
    end
  end

  always_ff @(posedge clk) begin
    if (!dq.hold) begin
      dq.op  <= op_dec;
      dq.rd  <= ifid_instr.r.rd;
      dq.rs1 <= rs1_id;
      dq.rs2 <= rs2_id;
      dq.opa <= rs1_val;
      // Immediate forms carry rs2 as x0, so no forwarding into opb
      dq.opb <= uses_rs2 ? rs2_val : imm_ext;
    end
  end

endmodule

`default_nettype wire

// File: design/hazard_detection_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard detection unit
// Load-use and multiplier stalls, bubble for load-use only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module hazard_detection_unit (
  // Instruction in EX
  input  logic                    idex_mem_read,
  input  logic [`CORE_REG_AW-1:0] idex_rd,
  // Sources of the instruction in ID
  input  logic [`CORE_REG_AW-1:0] ifid_rs1,
  input  logic [`CORE_REG_AW-1:0] ifid_rs2,
  // Multiplier state
  input  logic                    mul_busy,
  input  logic                    idex_is_mul,
  input  logic                    mul_done,
  output logic                    stall_pc,
  output logic                    stall_ifid,
  output logic                    bubble_idex
);

  logic rs1_hit;
  logic rs2_hit;
  logic load_use;
  logic mul_stall;

  // x0 never creates a dependency
  assign rs1_hit = (idex_rd == ifid_rs1) && (idex_rd != '0);
  assign rs2_hit = (idex_rd == ifid_rs2) && (idex_rd != '0);

  // Load in EX feeding the instruction in ID, one bubble
  assign load_use = idex_mem_read && (rs1_hit || rs2_hit);

  // Covers the first EX cycle before busy rises
  // Released on done so the MUL can leave EX
  assign mul_stall = (mul_busy || idex_is_mul) && !mul_done;

  assign stall_pc    = load_use || mul_stall;
  assign stall_ifid  = load_use || mul_stall;
  // Multiplier waits through hold, no bubble needed
  assign bubble_idex = load_use;

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage
// Four-phase instruction requester with a one-word buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module fetch_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  output logic                  imem_req,
  output logic [`CORE_XLEN-1:0] imem_addr,
  input  logic                  imem_ack,
  input  logic [`CORE_XLEN-1:0] imem_data,
  fetch_if.producer             fq
);

  // Handshake phases
  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_REQ  = 2'd1;
  localparam logic [1:0] S_DROP = 2'd2;

  logic [1:0]            state;
  logic                  buf_valid;
  logic [`CORE_XLEN-1:0] buf_word;
  logic [`CORE_XLEN-1:0] addr;
  logic                  take;
  logic                  buf_free;
  logic                  capture;

  // Decode takes the buffered word
  assign take     = buf_valid && !fq.stall;
  // Buffer empty now or emptied at this edge
  assign buf_free = !buf_valid || take;
  assign capture  = (state == S_REQ) && imem_ack;

  assign imem_req  = (state == S_REQ);
  // Address only moves on a take, never while req is up
  assign imem_addr = addr;

  assign fq.valid = buf_valid;
  assign fq.instr = buf_word;
  assign fq.pc    = addr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      buf_valid <= 1'b0;
      addr      <= '0;
    end else begin
      case (state)
        S_IDLE: if (buf_free) state <= S_REQ;
        S_REQ:  if (imem_ack) state <= S_DROP;
        // Wait for ack low before any new request
        S_DROP: if (!imem_ack) state <= buf_free ? S_REQ : S_IDLE;
        default: state <= S_IDLE;
      endcase
      if (capture) begin
        buf_valid <= 1'b1;
      end else if (take) begin
        buf_valid <= 1'b0;
      end
      if (take) begin
        addr <= addr + `CORE_XLEN'(4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      buf_word <= imem_data;
    end
  end

endmodule

`default_nettype wire

// File: design/pipe_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline interfaces
// Fetch to decode, decode to execute, execute to memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

// Word taken when valid and not stall
interface fetch_if ();
  logic                  valid;
  logic [`CORE_XLEN-1:0] instr;
  logic [`CORE_XLEN-1:0] pc;
  logic                  stall;
  modport producer (output valid, instr, pc, input stall);
  modport consumer (input valid, instr, pc, output stall);
endinterface

// Hold comes back from execute while the multiplier runs
interface id_ex_if import core_pkg::*; ();
  logic                    valid;
  alu_op_e                 op;
  logic [`CORE_REG_AW-1:0] rd;
  logic [`CORE_REG_AW-1:0] rs1;
  logic [`CORE_REG_AW-1:0] rs2;
  logic [`CORE_XLEN-1:0]   opa;
  logic [`CORE_XLEN-1:0]   opb;
  logic                    hold;
  modport producer (output valid, op, rd, rs1, rs2, opa, opb, input hold);
  modport consumer (input valid, op, rd, rs1, rs2, opa, opb, output hold);
endinterface

// Result is the byte address for a load
interface ex_wb_if import core_pkg::*; ();
  logic                    valid;
  alu_op_e                 op;
  logic [`CORE_REG_AW-1:0] rd;
  logic [`CORE_XLEN-1:0]   result;
  modport producer (output valid, op, rd, result);
  modport consumer (input valid, op, rd, result);
endinterface

`default_nettype wire

// File: design/core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core package
// Instruction word views and the execute operation code
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "core_consts.svh"

package core_pkg;

  // Register-register format
  typedef struct packed {
    logic [6:0]              funct7;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [2:0]              funct3;
    logic [`CORE_REG_AW-1:0] rd;
    logic [6:0]              opcode;
  } instr_r_t;

  // Immediate format, rs2 and funct7 replaced by imm
  typedef struct packed {
    logic [11:0]             imm;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [2:0]              funct3;
    logic [`CORE_REG_AW-1:0] rd;
    logic [6:0]              opcode;
  } instr_i_t;

  // Same 32 bits seen through either format
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_word_u;

  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_MUL  = 2'd1,
    OP_LOAD = 2'd2
  } alu_op_e;

endpackage

`default_nettype wire

// File: design/core_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core constants
// Widths, sizes, opcodes and data memory seed of the pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and register file
`define CORE_XLEN        32
`define CORE_REG_AW      5
`define CORE_REG_NUM     32

// Data memory, 16 words
`define CORE_DMEM_AW     4
`define CORE_DMEM_WORDS  16
// Word i holds seed xor i after reset
`define CORE_DMEM_SEED   32'h1357_9BD0

// RISC-V major opcodes kept by the core
`define CORE_OPC_OP      7'b0110011
`define CORE_OPC_OPIMM   7'b0010011
`define CORE_OPC_LOAD    7'b0000011
`define CORE_F7_MUL      7'b0000001

// Shift-add steps of the multiplier
`define CORE_MUL_CYCLES  32

`endif
